// ==== rtl/wb_sim_pkg.sv ====
`default_nettype none

package wb_sim_pkg;

    // --------------------
    // bus geometry
    // --------------------
    localparam int WB_DATA_W = 32;             // data and address width
    localparam int WB_SEL_W  = WB_DATA_W / 8;  // one enable per byte lane

    typedef logic [WB_DATA_W-1:0] wb_word_t;  // bus word or address
    typedef logic [WB_SEL_W-1:0]  wb_sel_t;   // byte-enable vector

    // --------------------
    // interrupt trigger
    // --------------------
    localparam int IRQ_MSW_BIT  = 3;   // machine software interrupt bit
    localparam int IRQ_MEXT_BIT = 11;  // machine external interrupt bit

    // memory model limits
    localparam int MAX_LATENCY = 255;  // deepest read/ack pipeline allowed

    // --------------------
    // default memory map
    // --------------------
    localparam wb_word_t DMEM_BASE_DEF = 32'h8000_0000;  // data memory
    localparam wb_word_t IO_BASE_DEF   = 32'hF000_0000;  // slow i/o window
    localparam wb_word_t IRQ_ADDR_DEF  = 32'hFF00_0000;  // single trigger word

endpackage : wb_sim_pkg

`default_nettype wire

// ==== rtl/wb_bus_if.sv ====
`default_nettype none

// one decoded link between the address decoder and a single peer
interface wb_bus_if import wb_sim_pkg::*; ();

    wb_word_t adr;   // byte address, broadcast
    wb_word_t wdat;  // write data, broadcast
    logic     we;    // 1 = write
    wb_sel_t  sel;   // byte enables
    logic     cyc;   // bus cycle in progress
    logic     stb;   // strobe, only for the addressed peer
    wb_word_t rdat;  // read data, zero while ack is low
    logic     ack;   // transfer done

    // decoder side
    modport master (
        output adr, wdat, we, sel, cyc, stb,
        input  rdat, ack
    );

    // peer side
    modport slave (
        input  adr, wdat, we, sel, cyc, stb,
        output rdat, ack
    );

endinterface : wb_bus_if

`default_nettype wire

// ==== rtl/wb_addr_decoder.sv ====
`default_nettype none

module wb_addr_decoder import wb_sim_pkg::*; #(
    parameter wb_word_t DMEM_BASE = DMEM_BASE_DEF,  // data memory base
    parameter int       DMEM_SIZE = 8 * 1024,       // data memory bytes
    parameter wb_word_t IO_BASE   = IO_BASE_DEF,    // i/o memory base
    parameter int       IO_SIZE   = 32,             // i/o memory bytes
    parameter wb_word_t IRQ_ADDR  = IRQ_ADDR_DEF    // trigger register address
) (
    input  wire      clk_gen,
    input  wire      rst_gen,
    input  wire      wb_word_t adr_i,   // master address
    input  wire      wb_word_t wdat_i,  // master write data
    input  wire      we_i,
    input  wire      wb_sel_t sel_i,
    input  wire      cyc_i,
    input  wire      stb_i,
    output wb_word_t rdat_o,            // combined read data
    output logic     ack_o,             // combined ack
    output logic     err_o,             // unmapped access, registered
    wb_bus_if.master dmem_bus,
    wb_bus_if.master io_bus,
    wb_bus_if.master irq_bus
);

    logic     req;       // strobed request from the master
    wb_word_t dmem_off;  // offset into data memory window
    wb_word_t io_off;    // offset into i/o window
    logic     hit_dmem;
    logic     hit_io;
    logic     hit_irq;

    assign req      = cyc_i & stb_i;
    assign dmem_off = adr_i - DMEM_BASE;                  // unsigned, wraps below base
    assign io_off   = adr_i - IO_BASE;
    assign hit_dmem = dmem_off < wb_word_t'(DMEM_SIZE);   // base <= adr < base+size
    assign hit_io   = io_off < wb_word_t'(IO_SIZE);
    assign hit_irq  = adr_i == IRQ_ADDR;                  // exactly one word

    // --------------------
    // request broadcast
    // --------------------
    assign dmem_bus.adr  = adr_i;
    assign dmem_bus.wdat = wdat_i;
    assign dmem_bus.we   = we_i;
    assign dmem_bus.sel  = sel_i;
    assign dmem_bus.cyc  = cyc_i;
    assign dmem_bus.stb  = stb_i & hit_dmem;  // steer strobe by region

    assign io_bus.adr    = adr_i;
    assign io_bus.wdat   = wdat_i;
    assign io_bus.we     = we_i;
    assign io_bus.sel    = sel_i;
    assign io_bus.cyc    = cyc_i;
    assign io_bus.stb    = stb_i & hit_io;

    assign irq_bus.adr   = adr_i;
    assign irq_bus.wdat  = wdat_i;
    assign irq_bus.we    = we_i;
    assign irq_bus.sel   = sel_i;
    assign irq_bus.cyc   = cyc_i;
    assign irq_bus.stb   = stb_i & hit_irq;

    // return path, peers gate their own data so a plain OR is enough
    assign rdat_o = dmem_bus.rdat | io_bus.rdat | irq_bus.rdat;
    assign ack_o  = dmem_bus.ack  | io_bus.ack  | irq_bus.ack;

    always_ff @(posedge clk_gen or negedge rst_gen) begin
        if (!rst_gen) begin
            err_o <= 1'b0;
        end else begin
            err_o <= req & ~(hit_dmem | hit_io | hit_irq) & ~err_o;  // single pulse per request
        end
    end

    // overlapping regions from the top level would strobe two peers
    a_one_peer: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        $onehot0({dmem_bus.stb, io_bus.stb, irq_bus.stb}))
        else $error("decoder strobed more than one peer at once");

endmodule : wb_addr_decoder

`default_nettype wire

// ==== rtl/wb_latency_mem.sv ====
`default_nettype none

module wb_latency_mem import wb_sim_pkg::*; #(
    parameter int MEM_SIZE = 1024,  // bytes, power of two, >= 4
    parameter int LATENCY  = 1      // read/ack pipeline depth
) (
    input  wire     clk_gen,
    input  wire     rst_gen,
    wb_bus_if.slave bus
);

    localparam int WORDS = MEM_SIZE / WB_SEL_W;               // 32-bit words
    localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;  // keep index at least 1 bit

    wb_word_t         mem [WORDS];       // storage, no reset
    wb_word_t         rd_pipe [LATENCY]; // read data delay line
    logic [LATENCY-1:0] ack_pipe;        // strobed-request delay line
    logic [LATENCY:0]   cyc_hist;        // cyc at the last LATENCY+1 edges, newest in bit 0
    logic [IDX_W-1:0] word_idx;          // word index from low address bits
    logic             req;               // strobed request this cycle

    // single-word memories have only index 0
    assign word_idx = bus.adr[IDX_W+1:2] & IDX_W'(WORDS - 1);
    assign req      = bus.cyc & bus.stb;

    // --------------------
    // write port
    // --------------------
    always_ff @(posedge clk_gen) begin
        if (req && bus.we) begin
            for (int b = 0; b < WB_SEL_W; b++) begin
                if (bus.sel[b]) begin
                    mem[word_idx][b*8 +: 8] <= bus.wdat[b*8 +: 8];  // enabled lanes only
                end
            end
        end
    end

    // --------------------
    // latency pipeline
    // --------------------
    always_ff @(posedge clk_gen) begin
        rd_pipe[0] <= mem[word_idx];  // addressed word, every cycle
        for (int i = 1; i < LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    always_ff @(posedge clk_gen or negedge rst_gen) begin
        if (!rst_gen) begin
            ack_pipe <= '0;
        end else begin
            ack_pipe[0] <= req;
            for (int i = 1; i < LATENCY; i++) begin
                ack_pipe[i] <= ack_pipe[i-1] & bus.cyc;  // abort kills acks in flight
            end
        end
    end

    // output register, data is zero unless acking
    always_ff @(posedge clk_gen or negedge rst_gen) begin
        if (!rst_gen) begin
            bus.rdat <= '0;
            bus.ack  <= 1'b0;
        end else if (ack_pipe[LATENCY-1] && bus.cyc && !bus.ack) begin  // no repeat while cyc falls
            bus.rdat <= rd_pipe[LATENCY-1];
            bus.ack  <= 1'b1;
        end else begin
            bus.rdat <= '0;
            bus.ack  <= 1'b0;
        end
    end

    // parameter range, checked at elaboration
    if (LATENCY < 1 || LATENCY > MAX_LATENCY) begin : g_bad_latency
        $error("wb_latency_mem: LATENCY %0d outside 1..%0d", LATENCY, MAX_LATENCY);
    end

    if (MEM_SIZE < 4 || (MEM_SIZE & (MEM_SIZE - 1)) != 0) begin : g_bad_size
        $error("wb_latency_mem: MEM_SIZE %0d is not a power of two >= 4", MEM_SIZE);
    end

    always_ff @(posedge clk_gen or negedge rst_gen) begin
        if (!rst_gen) begin
            cyc_hist <= '0;
        end else begin
            cyc_hist <= {cyc_hist[LATENCY-1:0], bus.cyc};  // request edge through ack edge
        end
    end

    // a dropped cycle must leave nothing behind in the pipeline
    a_no_late_ack: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        bus.ack |-> (&cyc_hist))
        else $error("memory ack after the master dropped cyc");

endmodule : wb_latency_mem

`default_nettype wire

// ==== rtl/wb_irq_trigger.sv ====
`default_nettype none

module wb_irq_trigger import wb_sim_pkg::*; (
    input  wire     clk_gen,
    input  wire     rst_gen,
    wb_bus_if.slave bus,
    output logic    msw_irq_o,   // machine software interrupt
    output logic    mext_irq_o   // machine external interrupt
);

    logic wr_full;  // strobed write with every byte lane enabled

    assign wr_full  = bus.cyc & bus.stb & bus.we & (&bus.sel);
    assign bus.rdat = '0;  // write-only register

    // --------------------
    // trigger register
    // --------------------
    always_ff @(posedge clk_gen or negedge rst_gen) begin
        if (!rst_gen) begin
            bus.ack    <= 1'b0;
            msw_irq_o  <= 1'b0;
            mext_irq_o <= 1'b0;
        end else begin
            bus.ack <= wr_full & ~bus.ack;  // reads and partial writes never ack
            if (wr_full) begin
                msw_irq_o  <= bus.wdat[IRQ_MSW_BIT];   // bit 3
                mext_irq_o <= bus.wdat[IRQ_MEXT_BIT];  // bit 11
            end
        end
    end

    // lines may only move together with a new ack
    a_irq_on_ack: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        ($changed(msw_irq_o) || $changed(mext_irq_o)) |-> $rose(bus.ack))
        else $error("interrupt line changed without a trigger write ack");

endmodule : wb_irq_trigger

`default_nettype wire

// ==== rtl/wb_sim_subsystem.sv ====
`default_nettype none

module wb_sim_subsystem import wb_sim_pkg::*; #(
    parameter wb_word_t DMEM_BASE    = DMEM_BASE_DEF,
    parameter int       DMEM_SIZE    = 8 * 1024,     // bytes
    parameter int       DMEM_LATENCY = 8,            // cycles, ack at +1
    parameter wb_word_t IO_BASE      = IO_BASE_DEF,
    parameter int       IO_SIZE      = 32,           // bytes
    parameter int       IO_LATENCY   = 128,          // deliberately slow
    parameter wb_word_t IRQ_ADDR     = IRQ_ADDR_DEF
) (
    input  wire      clk_gen,
    input  wire      rst_gen,       // async, active low
    input  wire      wb_word_t wb_adr_i,
    input  wire      wb_word_t wb_dat_i,
    input  wire      wb_we_i,
    input  wire      wb_sel_t wb_sel_i,
    input  wire      wb_stb_i,
    input  wire      wb_cyc_i,
    output wb_word_t wb_dat_o,      // read data
    output logic     wb_ack_o,
    output logic     wb_err_o,      // unmapped address
    output logic     msw_irq_o,
    output logic     mext_irq_o
);

    // one link per peer
    wb_bus_if dmem_bus ();
    wb_bus_if io_bus ();
    wb_bus_if irq_bus ();

    // --------------------
    // decode and return
    // --------------------
    wb_addr_decoder #(
        .DMEM_BASE (DMEM_BASE),
        .DMEM_SIZE (DMEM_SIZE),
        .IO_BASE   (IO_BASE),
        .IO_SIZE   (IO_SIZE),
        .IRQ_ADDR  (IRQ_ADDR)
    ) u_decoder (
        .clk_gen  (clk_gen),
        .rst_gen  (rst_gen),
        .adr_i    (wb_adr_i),
        .wdat_i   (wb_dat_i),
        .we_i     (wb_we_i),
        .sel_i    (wb_sel_i),
        .cyc_i    (wb_cyc_i),
        .stb_i    (wb_stb_i),
        .rdat_o   (wb_dat_o),
        .ack_o    (wb_ack_o),
        .err_o    (wb_err_o),
        .dmem_bus (dmem_bus.master),
        .io_bus   (io_bus.master),
        .irq_bus  (irq_bus.master)
    );

    // --------------------
    // peers
    // --------------------
    wb_latency_mem #(
        .MEM_SIZE (DMEM_SIZE),
        .LATENCY  (DMEM_LATENCY)
    ) u_dmem (
        .clk_gen (clk_gen),
        .rst_gen (rst_gen),
        .bus     (dmem_bus.slave)
    );

    wb_latency_mem #(
        .MEM_SIZE (IO_SIZE),
        .LATENCY  (IO_LATENCY)
    ) u_io (
        .clk_gen (clk_gen),
        .rst_gen (rst_gen),
        .bus     (io_bus.slave)
    );

    wb_irq_trigger u_irq (
        .clk_gen    (clk_gen),
        .rst_gen    (rst_gen),
        .bus        (irq_bus.slave),
        .msw_irq_o  (msw_irq_o),
        .mext_irq_o (mext_irq_o)
    );

endmodule : wb_sim_subsystem

`default_nettype wire

// ==== verif/wb_sim_tb.sv ====
`default_nettype none

module wb_sim_tb import wb_sim_pkg::*; ();

    localparam int DMEM_SIZE    = 256;
    localparam int DMEM_LATENCY = 4;
    localparam int IO_SIZE      = 32;
    localparam int IO_LATENCY   = 9;
    localparam int DMEM_AW      = $clog2(DMEM_SIZE);  // byte index widths of the models
    localparam int IO_AW        = $clog2(IO_SIZE);
    localparam int LIMIT        = IO_LATENCY + 4;     // edges before a silent request is dropped
    localparam int N_RAND       = 32;
    localparam int N_TRANS      = DMEM_SIZE / 4 + IO_SIZE / 4 + 2 * N_RAND + 16 + 7 + 3 + 2;
    localparam int WATCHDOG_T   = N_TRANS * (IO_LATENCY + 4) * 8 + 200 * 8;

    logic     clk_gen = 1'b0;
    logic     rst_gen;
    wb_word_t wb_adr_i;
    wb_word_t wb_dat_i;
    logic     wb_we_i;
    wb_sel_t  wb_sel_i;
    logic     wb_stb_i;
    logic     wb_cyc_i;
    wb_word_t wb_dat_o;
    logic     wb_ack_o;
    logic     wb_err_o;
    logic     msw_irq_o;
    logic     mext_irq_o;

    // expected response of the request on the bus
    int       exp_lat;   // edge count at which ack or err is due
    logic     exp_ack;
    logic     exp_err;
    logic     exp_we;
    logic     exp_irq;   // full trigger write
    logic     exp_msw;
    logic     exp_mext;
    wb_word_t exp_dat;

    int          req_edges;                 // edges since the request was first sampled
    int          xfer_cnt;
    int          mismatch_cnt;
    int          fault_cnt;
    logic [31:0] rnd_state;
    logic [7:0]  dmem_model [DMEM_SIZE];   // expected bytes
    logic [7:0]  io_model [IO_SIZE];
    int          wr_offs [$];               // words hit by random writes

    always #4 clk_gen = ~clk_gen;

    wb_sim_subsystem #(
        .DMEM_SIZE    (DMEM_SIZE),
        .DMEM_LATENCY (DMEM_LATENCY),
        .IO_SIZE      (IO_SIZE),
        .IO_LATENCY   (IO_LATENCY)
    ) i_wb_sim_subsystem (
        .clk_gen    (clk_gen),
        .rst_gen    (rst_gen),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_we_i    (wb_we_i),
        .wb_sel_i   (wb_sel_i),
        .wb_stb_i   (wb_stb_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .wb_err_o   (wb_err_o),
        .msw_irq_o  (msw_irq_o),
        .mext_irq_o (mext_irq_o)
    );

    always @(posedge clk_gen or negedge rst_gen) begin
        if (!rst_gen) begin
            req_edges <= 0;
        end else if (wb_cyc_i && wb_stb_i) begin
            req_edges <= req_edges + 1;  // 1 after the first sampled edge
        end else begin
            req_edges <= 0;
        end
    end

    // --------------------
    // checks
    // --------------------
    a_ack_timing: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        (wb_cyc_i && wb_stb_i) |-> (wb_ack_o == (exp_ack && req_edges == exp_lat)))
        else begin
            mismatch_cnt++;
            $display("mismatch wb_ack_o at %h edge %0d: got %h expected %h",
                     $sampled(wb_adr_i), $sampled(req_edges), $sampled(wb_ack_o),
                     $sampled(exp_ack && req_edges == exp_lat));
        end

    a_err_timing: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        (wb_cyc_i && wb_stb_i) |-> (wb_err_o == (exp_err && req_edges == 1)))
        else begin
            mismatch_cnt++;
            $display("mismatch wb_err_o at %h edge %0d: got %h expected %h",
                     $sampled(wb_adr_i), $sampled(req_edges), $sampled(wb_err_o),
                     $sampled(exp_err && req_edges == 1));
        end

    a_read_data: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        (wb_cyc_i && wb_ack_o && !exp_we) |-> (wb_dat_o == exp_dat))
        else begin
            mismatch_cnt++;
            $display("mismatch wb_dat_o at %h: got %h expected %h",
                     $sampled(wb_adr_i), $sampled(wb_dat_o), $sampled(exp_dat));
        end

    a_msw_value: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        (wb_cyc_i && wb_ack_o && exp_irq) |-> (msw_irq_o == exp_msw))
        else begin
            mismatch_cnt++;
            $display("mismatch msw_irq_o: got %h expected %h",
                     $sampled(msw_irq_o), $sampled(exp_msw));
        end

    a_mext_value: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        (wb_cyc_i && wb_ack_o && exp_irq) |-> (mext_irq_o == exp_mext))
        else begin
            mismatch_cnt++;
            $display("mismatch mext_irq_o: got %h expected %h",
                     $sampled(mext_irq_o), $sampled(exp_mext));
        end

    a_irq_hold: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        ($changed(msw_irq_o) || $changed(mext_irq_o)) |-> (wb_cyc_i && wb_ack_o && exp_irq))
        else begin
            fault_cnt++;
            $display("interrupt lines moved without a full trigger write, adr %h",
                     $sampled(wb_adr_i));
        end

    // a response while cyc is low is a repeated ack or an aborted read coming back
    a_bus_quiet: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        !wb_cyc_i |-> (!wb_ack_o && !wb_err_o))
        else begin
            fault_cnt++;
            $display("ack or err seen while cyc was low");
        end

    // --------------------
    // stimulus helpers
    // --------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic roll(output logic [31:0] val);
        rnd_state = lcg_next(rnd_state);
        val       = rnd_state;
    endtask

    function automatic wb_word_t addr_pattern(input wb_word_t adr);
        return (adr * 32'h9e37_79b9) ^ {adr[15:0], adr[31:16]};  // every address bit counts
    endfunction

    task automatic model_write(input logic is_io, input int off, input wb_word_t dat,
                               input wb_sel_t sel);
        for (int b = 0; b < WB_SEL_W; b++) begin
            if (sel[b] && is_io) begin
                io_model[IO_AW'(off + b)] = dat[b*8 +: 8];
            end else if (sel[b]) begin
                dmem_model[DMEM_AW'(off + b)] = dat[b*8 +: 8];
            end
        end
    endtask

    function automatic wb_word_t model_word(input logic is_io, input int off);
        wb_word_t w;
        for (int b = 0; b < WB_SEL_W; b++) begin
            w[b*8 +: 8] = is_io ? io_model[IO_AW'(off + b)] : dmem_model[DMEM_AW'(off + b)];
        end
        return w;
    endfunction

    // one classic cycle, dropped at the first ack or err or after limit edges
    task automatic run_xfer(
        input wb_word_t adr,
        input wb_word_t dat,
        input logic     we,
        input wb_sel_t  sel,
        input int       lat,
        input logic     ack,
        input logic     err,
        input logic     irq,
        input wb_word_t rdat,
        input int       limit
    );
        int n;
        @(posedge clk_gen);
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        wb_we_i  <= we;
        wb_sel_i <= sel;
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        exp_lat  <= lat;
        exp_ack  <= ack;
        exp_err  <= err;
        exp_we   <= we;
        exp_irq  <= irq;
        exp_dat  <= rdat;
        exp_msw  <= dat[IRQ_MSW_BIT];
        exp_mext <= dat[IRQ_MEXT_BIT];
        n = 0;
        do begin
            @(posedge clk_gen);
            n++;
        end while (!wb_ack_o && !wb_err_o && n < limit);
        wb_cyc_i <= 1'b0;  // same edge the response was seen
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        xfer_cnt++;
    endtask

    task automatic mem_access(input logic is_io, input logic we, input int off,
                              input wb_word_t dat, input wb_sel_t sel);
        wb_word_t base;
        int       lat;
        base = is_io ? IO_BASE_DEF : DMEM_BASE_DEF;
        lat  = (is_io ? IO_LATENCY : DMEM_LATENCY) + 1;
        if (we) begin
            model_write(is_io, off, dat, sel);  // kept bytes stay as they were
        end
        run_xfer(base + wb_word_t'(off), dat, we, sel, lat, 1'b1, 1'b0, 1'b0,
                 model_word(is_io, off), LIMIT);
    endtask

    task automatic irq_access(input logic we, input wb_word_t dat, input wb_sel_t sel);
        logic full;
        full = we && (sel == 4'hf);  // only this form is accepted
        run_xfer(IRQ_ADDR_DEF, dat, we, sel, 1, full, 1'b0, full, '0, LIMIT);
    endtask

    task automatic aborted_read(input logic is_io, input int off, input int stop);
        wb_word_t base;
        base = is_io ? IO_BASE_DEF : DMEM_BASE_DEF;
        run_xfer(base + wb_word_t'(off), '0, 1'b0, 4'hf, 1, 1'b0, 1'b0, 1'b0, '0, stop);
        repeat (IO_LATENCY + 4) @(posedge clk_gen);  // window where a stray ack would show
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        logic [31:0] r;
        logic [31:0] d;
        int          off;
        rnd_state    = 32'h4a89;
        xfer_cnt     = 0;
        mismatch_cnt = 0;
        fault_cnt    = 0;
        rst_gen      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        wb_we_i      = 1'b0;
        wb_sel_i     = '0;
        wb_stb_i     = 1'b0;
        wb_cyc_i     = 1'b0;
        exp_lat      = 0;
        exp_ack      = 1'b0;
        exp_err      = 1'b0;
        exp_we       = 1'b0;
        exp_irq      = 1'b0;
        exp_msw      = 1'b0;
        exp_mext     = 1'b0;
        exp_dat      = '0;
        repeat (3) @(posedge clk_gen);
        rst_gen <= 1'b1;

        // fill both rams so the model knows every byte
        for (int a = 0; a < DMEM_SIZE; a += 4) begin
            mem_access(1'b0, 1'b1, a, addr_pattern(DMEM_BASE_DEF + wb_word_t'(a)), 4'hf);
        end
        for (int a = 0; a < IO_SIZE; a += 4) begin
            mem_access(1'b1, 1'b1, a, addr_pattern(IO_BASE_DEF + wb_word_t'(a)), 4'hf);
        end

        for (int i = 0; i < N_RAND; i++) begin
            roll(r);
            roll(d);
            off = int'(r[23:16]) % (DMEM_SIZE / 4) * 4;
            wr_offs.push_back(off);
            mem_access(1'b0, 1'b1, off, d, r[11:8]);  // random lanes, zero included
        end
        foreach (wr_offs[i]) begin
            mem_access(1'b0, 1'b0, wr_offs[i], '0, 4'hf);
        end

        // same offset in both windows must not alias
        for (int i = 0; i < 4; i++) begin
            roll(r);
            roll(d);
            off = int'(r[20:16]) % (IO_SIZE / 4) * 4;
            mem_access(1'b0, 1'b1, off, d, 4'hf);
            mem_access(1'b1, 1'b1, off, ~d, 4'hf);
            mem_access(1'b0, 1'b0, off, '0, 4'hf);
            mem_access(1'b1, 1'b0, off, '0, 4'hf);
        end

        irq_access(1'b1, 32'h0000_0808, 4'hf);  // both lines up
        irq_access(1'b1, 32'h0000_0000, 4'h3);  // partial, ignored
        irq_access(1'b0, 32'h0000_0000, 4'hf);  // read, ignored
        irq_access(1'b1, 32'h0000_0008, 4'hf);
        irq_access(1'b1, 32'h0000_0800, 4'hf);
        roll(d);
        irq_access(1'b1, d, 4'hf);
        irq_access(1'b1, 32'h0000_0000, 4'hf);

        // just past each window and next to the trigger word
        run_xfer(DMEM_BASE_DEF + DMEM_SIZE, '0, 1'b0, 4'hf, 1, 1'b0, 1'b1, 1'b0, '0, LIMIT);
        run_xfer(IO_BASE_DEF + IO_SIZE, '0, 1'b0, 4'hf, 1, 1'b0, 1'b1, 1'b0, '0, LIMIT);
        run_xfer(IRQ_ADDR_DEF + 4, '0, 1'b0, 4'hf, 1, 1'b0, 1'b1, 1'b0, '0, LIMIT);

        aborted_read(1'b0, 8, 2);
        aborted_read(1'b1, 4, 4);

        repeat (4) @(posedge clk_gen);
        $display("transactions %0d, value mismatches %0d, other errors %0d",
                 xfer_cnt, mismatch_cnt, fault_cnt);
        if (mismatch_cnt == 0 && fault_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_T);
        $display("watchdog expired after %0d time units, the run did not complete",
                 WATCHDOG_T);
        $display("transactions %0d, value mismatches %0d, other errors %0d",
                 xfer_cnt, mismatch_cnt, fault_cnt);
        $display("=== FAIL ===");
        $finish;
    end

endmodule : wb_sim_tb

`default_nettype wire

// ==== all.f ====
rtl/wb_sim_pkg.sv
rtl/wb_bus_if.sv
rtl/wb_addr_decoder.sv
rtl/wb_latency_mem.sv
rtl/wb_irq_trigger.sv
rtl/wb_sim_subsystem.sv
verif/wb_sim_tb.sv

// ==== Makefile ====
TOP := wb_sim_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '=== PASS ===' > /dev/null

obj_dir/V$(TOP): all.f $(wildcard rtl/*.sv verif/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f

lint:
	verilator --lint-only --timing --top-module wb_sim_subsystem -f all.f

clean:
	rm -rf obj_dir
